//--- Makefile
TOP = readout_tx_tb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f readout_tx.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- readout_tx.f
verilog/packet_pkg.sv
verilog/tx_cfg_pkg.sv
verilog/packet_assembler.sv
verilog/packet_fifo.sv
verilog/tx_control.sv
verilog/tx_shifter.sv
verilog/powerup_timer.sv
verilog/readout_tx.sv
verification/readout_tx_tb.sv

//--- verification/readout_tx_tb.sv
module readout_tx_tb
    import packet_pkg::*;
    import tx_cfg_pkg::*;
();

    // DUT inputs
    logic           txclk = 1'b0;
    logic           reset_n;
    logic           tx_enable;
    logic           push;
    logic           enable_dynamic_powerdown;
    packet_fields_t fields;
    powerup_code_t  powerup_code;

    // DUT outputs
    logic           tx_out;
    logic           tx_busy;
    logic           tx_powerdown;
    logic           fifo_full;

    // packets accepted by the FIFO and not yet seen on the line
    packet_t        expected_q[$];

    logic [31:0]    rng_state = 32'hb7a1;
    int             errors = 0;
    // counted by the stall monitor
    int             hold_errors = 0;
    int             tests_run = 0;
    int             tests_failed = 0;

    // enable and line level at the previous rising edge
    logic           en_last;
    logic           out_last;

    readout_tx dut (
        .txclk                    (txclk),
        .reset_n                  (reset_n),
        .tx_enable                (tx_enable),
        .push                     (push),
        .enable_dynamic_powerdown (enable_dynamic_powerdown),
        .fields                   (fields),
        .powerup_code             (powerup_code),
        .tx_out                   (tx_out),
        .tx_busy                  (tx_busy),
        .tx_powerdown             (tx_powerdown),
        .fifo_full                (fifo_full)
    );

    initial begin
        forever begin
            #5 txclk = ~txclk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic packet_fields_t random_fields();
        logic [63:0] r;
        r = {next_random(), next_random()};
        return r[62:0];
    endfunction

    // field positions and odd parity of the readout packet
    function automatic packet_t expected_packet(input packet_fields_t f);
        packet_t p;
        p = '0;
        p[1:0] = f.pkt_type;
        p[9:2] = f.chip_id;
        p[15:10] = f.channel_id;
        p[47:16] = f.timestamp;
        p[55:48] = f.adc_word;
        p[57:56] = f.trigger_type;
        p[59:58] = f.local_fifo_status;
        p[61:60] = f.shared_fifo_status;
        p[62] = f.downstream;
        // an even count of ones in the fields needs a parity one
        p[63] = (($countones(p[62:0]) % 2) == 0);
        return p;
    endfunction

    // four enabled cycles per code step, codes 0 and 1 alike
    function automatic int decoded_delay(input int code);
        if (code < 2) begin
            return 4;
        end
        return 4 * code;
    endfunction

    function automatic int error_total();
        return errors + hold_errors;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic value_error(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", name, what, expected, actual);
        errors++;
    endtask

    task automatic report_test(input string name, input int first_error);
        tests_run++;
        if (error_total() == first_error) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_total() - first_error);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and capture
    //////////////////////////////////////////////////////////////////////

    // caller is on a falling edge
    task automatic drive_push(input packet_fields_t f);
        push = 1'b1;
        fields = f;
        // a full FIFO loses the packet
        if (expected_q.size() < 4) begin
            expected_q.push_back(expected_packet(f));
        end
    endtask

    task automatic idle_gap();
        int n;
        n = int'((next_random() >> 16) % 8);
        repeat (n + 1) @(negedge txclk);
    endtask

    task automatic wait_enabled(input string name, input string what);
        int guard;
        guard = 0;
        @(posedge txclk);
        while (!tx_enable && guard < 50) begin
            @(posedge txclk);
            guard++;
        end
        if (!tx_enable) begin
            $display("%s: timed out waiting for an enabled cycle on the %s", name, what);
            errors++;
        end
    endtask

    // line sampled on each enabled rising edge
    task automatic capture_frame(input string name, output packet_t data,
                                 output int idle_seen, output int wake_seen,
                                 output int busy_seen);
        int guard;
        bit found;
        data = '0;
        idle_seen = 0;
        wake_seen = 0;
        busy_seen = 0;
        found = 1'b0;
        guard = 0;
        // hunt for the start bit
        while (!found && guard < 500) begin
            @(posedge txclk);
            guard++;
            if (tx_enable) begin
                if (tx_busy) begin
                    busy_seen++;
                end
                if (!tx_busy && tx_powerdown !== enable_dynamic_powerdown) begin
                    value_error(name, "idle tx_powerdown",
                                64'(enable_dynamic_powerdown), 64'(tx_powerdown));
                end
                if (tx_out === 1'b0) begin
                    found = 1'b1;
                end else begin
                    idle_seen++;
                    // busy with a high line means the PHY is waking up
                    if (tx_busy) begin
                        wake_seen++;
                        if (tx_powerdown !== 1'b0) begin
                            value_error(name, "power-up tx_powerdown", 64'd0, 64'(tx_powerdown));
                        end
                    end
                end
            end
        end
        if (!found) begin
            $display("%s: timed out waiting for a start bit", name);
            errors++;
        end else begin
            for (int i = 0; i < 64; i++) begin
                wait_enabled(name, "data bit");
                data[i] = tx_out;
                if (tx_busy) begin
                    busy_seen++;
                end
            end
            wait_enabled(name, "stop bit");
            if (tx_busy) begin
                busy_seen++;
            end
            if (tx_out !== 1'b1) begin
                $display("%s: stop bit missing after the data bits", name);
                errors++;
            end
        end
    endtask

    task automatic check_frame(input string name, input packet_t got);
        packet_t expected;
        if (expected_q.size() == 0) begin
            $display("%s: a frame was sent with no packet left in the model", name);
            errors++;
        end else begin
            expected = expected_q.pop_front();
            if (got !== expected) begin
                value_error(name, "packet", expected, got);
            end
        end
        if (^got !== 1'b1) begin
            value_error(name, "parity", 64'd1, 64'(^got));
        end
    endtask

    // a line level must survive every stalled cycle
    always @(posedge txclk) begin
        if (!reset_n) begin
            en_last <= 1'b1;
            out_last <= 1'b1;
        end else begin
            if (!en_last && tx_out !== out_last) begin
                $display("tx_out changed across a stalled cycle at time %0t", $time);
                hold_errors++;
            end
            en_last <= tx_enable;
            out_last <= tx_out;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        int first_error;
        first_error = error_total();
        if (tx_out !== 1'b1) begin
            value_error("reset_values", "tx_out", 64'd1, 64'(tx_out));
        end
        if (tx_busy !== 1'b0) begin
            value_error("reset_values", "tx_busy", 64'd0, 64'(tx_busy));
        end
        if (tx_powerdown !== 1'b0) begin
            value_error("reset_values", "tx_powerdown", 64'd0, 64'(tx_powerdown));
        end
        if (fifo_full !== 1'b0) begin
            value_error("reset_values", "fifo_full", 64'd0, 64'(fifo_full));
        end
        report_test("reset_values", first_error);
    endtask

    task automatic single_packet();
        packet_t got;
        int idle_seen;
        int wake_seen;
        int busy_seen;
        int first_error;
        first_error = error_total();
        @(negedge txclk);
        enable_dynamic_powerdown = 1'b0;
        drive_push(random_fields());
        @(negedge txclk);
        push = 1'b0;
        capture_frame("single_packet", got, idle_seen, wake_seen, busy_seen);
        check_frame("single_packet", got);
        // start, 64 data bits, stop
        if (busy_seen != 66) begin
            value_error("single_packet", "busy cycles", 64'd66, 64'(busy_seen));
        end
        wait_enabled("single_packet", "cycle after stop");
        if (tx_busy !== 1'b0) begin
            value_error("single_packet", "tx_busy after stop", 64'd0, 64'(tx_busy));
        end
        report_test("single_packet", first_error);
    endtask

    task automatic back_to_back();
        packet_t got;
        int idle_seen;
        int wake_seen;
        int busy_seen;
        int first_error;
        first_error = error_total();
        fork
            begin
                // four pushes on successive cycles
                for (int j = 0; j < 4; j++) begin
                    @(negedge txclk);
                    drive_push(random_fields());
                end
                @(negedge txclk);
                push = 1'b0;
            end
            begin
                for (int k = 0; k < 4; k++) begin
                    capture_frame("back_to_back", got, idle_seen, wake_seen, busy_seen);
                    check_frame("back_to_back", got);
                    // only the stop bit separates chained frames
                    if (k > 0 && idle_seen != 0) begin
                        value_error("back_to_back", "idle cycles between frames",
                                    64'd0, 64'(idle_seen));
                    end
                end
            end
        join
        report_test("back_to_back", first_error);
    endtask

    task automatic fifo_overflow();
        packet_t got;
        int idle_seen;
        int wake_seen;
        int busy_seen;
        int first_error;
        first_error = error_total();
        @(negedge txclk);
        // line stalled, nothing leaves the FIFO
        tx_enable = 1'b0;
        for (int k = 0; k < 6; k++) begin
            @(negedge txclk);
            if (fifo_full !== (k >= 4)) begin
                value_error("fifo_overflow", "fifo_full", 64'(k >= 4), 64'(fifo_full));
            end
            drive_push(random_fields());
        end
        @(negedge txclk);
        push = 1'b0;
        if (fifo_full !== 1'b1) begin
            value_error("fifo_overflow", "fifo_full", 64'd1, 64'(fifo_full));
        end
        tx_enable = 1'b1;
        for (int k = 0; k < 4; k++) begin
            capture_frame("fifo_overflow", got, idle_seen, wake_seen, busy_seen);
            check_frame("fifo_overflow", got);
        end
        // the dropped packets must never reach the line
        for (int k = 0; k < 80; k++) begin
            @(posedge txclk);
            if (tx_busy !== 1'b0) begin
                $display("fifo_overflow: a dropped packet was transmitted");
                errors++;
                break;
            end
        end
        if (expected_q.size() != 0) begin
            value_error("fifo_overflow", "packets left", 64'd0, 64'(expected_q.size()));
        end
        report_test("fifo_overflow", first_error);
    endtask

    task automatic enable_stall();
        packet_t got;
        int idle_seen;
        int wake_seen;
        int busy_seen;
        int first_error;
        int guard;
        bit done;
        first_error = error_total();
        done = 1'b0;
        guard = 0;
        @(negedge txclk);
        drive_push(random_fields());
        @(negedge txclk);
        push = 1'b0;
        fork
            begin
                capture_frame("enable_stall", got, idle_seen, wake_seen, busy_seen);
                done = 1'b1;
            end
            begin
                // roughly one stalled cycle in three
                while (!done && guard < 2000) begin
                    @(negedge txclk);
                    guard++;
                    tx_enable = ((next_random() >> 16) % 3) != 0;
                end
            end
        join
        tx_enable = 1'b1;
        check_frame("enable_stall", got);
        report_test("enable_stall", first_error);
    endtask

    task automatic dynamic_powerdown();
        packet_t got;
        int idle_seen;
        int wake_seen;
        int busy_seen;
        int first_error;
        first_error = error_total();
        for (int c = 0; c < 8; c++) begin
            @(negedge txclk);
            enable_dynamic_powerdown = 1'b1;
            powerup_code = c[2:0];
            @(negedge txclk);
            // PHY asleep while nothing is queued
            if (tx_powerdown !== 1'b1) begin
                value_error("dynamic_powerdown", "idle tx_powerdown", 64'd1, 64'(tx_powerdown));
            end
            drive_push(random_fields());
            @(negedge txclk);
            push = 1'b0;
            capture_frame("dynamic_powerdown", got, idle_seen, wake_seen, busy_seen);
            check_frame("dynamic_powerdown", got);
            if (wake_seen != decoded_delay(c)) begin
                value_error("dynamic_powerdown", "power-up cycles",
                            64'(decoded_delay(c)), 64'(wake_seen));
            end
        end
        @(negedge txclk);
        enable_dynamic_powerdown = 1'b0;
        report_test("dynamic_powerdown", first_error);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n = 1'b0;
        tx_enable = 1'b1;
        push = 1'b0;
        enable_dynamic_powerdown = 1'b0;
        fields = '0;
        powerup_code = '0;
        // three rising edges in reset
        repeat (3) @(negedge txclk);
        reset_values();
        reset_n = 1'b1;
        single_packet();
        idle_gap();
        back_to_back();
        idle_gap();
        fifo_overflow();
        idle_gap();
        enable_stall();
        idle_gap();
        dynamic_powerdown();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/packet_assembler.sv
module packet_assembler
    import packet_pkg::*;
(
    input  packet_fields_t fields,
    output packet_t        packet
);

    // packet body without the parity bit
    packet_t payload;

    //////////////////////////////////////////////////////////////////////
    // field placement
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        payload = '0;
        // header
        payload[PKT_TYPE_LSB +: PKT_TYPE_WIDTH] = fields.pkt_type;
        payload[CHIP_ID_LSB +: CHIP_ID_WIDTH] = fields.chip_id;
        payload[CHANNEL_ID_LSB +: CHANNEL_ID_WIDTH] = fields.channel_id;
        // hit content
        payload[TIMESTAMP_LSB +: TIMESTAMP_WIDTH] = fields.timestamp;
        payload[ADC_WORD_LSB +: ADC_WORD_WIDTH] = fields.adc_word;
        payload[TRIGGER_LSB +: TRIGGER_WIDTH] = fields.trigger_type;
        // buffer status from the local and shared FIFOs
        payload[LOCAL_FIFO_LSB +: FIFO_STATUS_WIDTH] = fields.local_fifo_status;
        payload[SHARED_FIFO_LSB +: FIFO_STATUS_WIDTH] = fields.shared_fifo_status;
        // set when the packet travels downstream
        payload[DOWNSTREAM_BIT] = fields.downstream;
    end

    //////////////////////////////////////////////////////////////////////
    // parity
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        packet = payload;
        // xnor reduce is 1 for an even count, making the total odd
        packet[PARITY_BIT] = ~^payload[PARITY_BIT-1:0];
    end

endmodule

//--- verilog/packet_fifo.sv
module packet_fifo
    import packet_pkg::*;
(
    input  logic    txclk,
    input  logic    reset_n,
    input  logic    push,
    input  packet_t push_data,
    input  logic    pop,
    output packet_t head,
    output logic    fifo_empty,
    output logic    fifo_full
);

    // storage
    packet_t     mem [FIFO_DEPTH];

    // circular pointers and occupancy
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    // qualified requests
    logic        do_push;
    logic        do_pop;

    // a push into a full buffer is lost, even with a pop alongside
    assign do_push = push && !fifo_full;
    assign do_pop = pop && !fifo_empty;

    assign fifo_empty = (count == '0);
    assign fifo_full = (count == fifo_count_t'(FIFO_DEPTH));

    // oldest entry is always presented
    assign head = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge txclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and count
    //////////////////////////////////////////////////////////////////////

    // depth is a power of two so pointers wrap on their own
    always_ff @(posedge txclk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- verilog/packet_pkg.sv
package packet_pkg;

    //////////////////////////////////////////////////////////////////////
    // packet geometry and buffering
    //////////////////////////////////////////////////////////////////////

    localparam int PACKET_WIDTH = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // field widths
    localparam int PKT_TYPE_WIDTH = 2;
    localparam int CHIP_ID_WIDTH = 8;
    localparam int CHANNEL_ID_WIDTH = 6;
    localparam int TIMESTAMP_WIDTH = 32;
    localparam int ADC_WORD_WIDTH = 8;
    localparam int TRIGGER_WIDTH = 2;
    localparam int FIFO_STATUS_WIDTH = 2;

    // lsb of each field inside the packet
    localparam int PKT_TYPE_LSB = 0;
    localparam int CHIP_ID_LSB = 2;
    localparam int CHANNEL_ID_LSB = 10;
    localparam int TIMESTAMP_LSB = 16;
    localparam int ADC_WORD_LSB = 48;
    localparam int TRIGGER_LSB = 56;
    localparam int LOCAL_FIFO_LSB = 58;
    localparam int SHARED_FIFO_LSB = 60;
    localparam int DOWNSTREAM_BIT = 62;
    localparam int PARITY_BIT = 63;

    typedef logic [PACKET_WIDTH-1:0] packet_t;
    typedef logic [CHIP_ID_WIDTH-1:0] chip_id_t;
    typedef logic [CHANNEL_ID_WIDTH-1:0] channel_id_t;
    typedef logic [TIMESTAMP_WIDTH-1:0] timestamp_t;
    typedef logic [ADC_WORD_WIDTH-1:0] adc_word_t;
    typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
    // one extra bit so a full buffer is distinct from an empty one
    typedef logic [FIFO_PTR_WIDTH:0] fifo_count_t;

    // field inputs, msb first, parity is added by the assembler
    // pkt_type codes 00 data, 01 test, 10 config write, 11 config read
    typedef struct packed {
        logic                         downstream;
        logic [FIFO_STATUS_WIDTH-1:0] shared_fifo_status;
        logic [FIFO_STATUS_WIDTH-1:0] local_fifo_status;
        logic [TRIGGER_WIDTH-1:0]     trigger_type;
        adc_word_t                    adc_word;
        timestamp_t                   timestamp;
        channel_id_t                  channel_id;
        chip_id_t                     chip_id;
        logic [PKT_TYPE_WIDTH-1:0]    pkt_type;
    } packet_fields_t;

endpackage

//--- verilog/powerup_timer.sv
module powerup_timer
    import tx_cfg_pkg::*;
(
    input  logic          txclk,
    input  logic          reset_n,
    input  logic          tx_enable,
    input  logic          timer_start,
    input  powerup_code_t powerup_code,
    output logic          timer_done
);

    // decoded wait in enabled cycles
    powerup_delay_t powerup_delay;
    // cycles left after the current one
    powerup_delay_t remaining;
    logic           running;

    // codes 0 and 1 share the shortest wait
    always_comb begin
        if (powerup_code == '0) begin
            powerup_delay = POWERUP_STEP;
        end else begin
            powerup_delay = POWERUP_STEP * powerup_delay_t'(powerup_code);
        end
    end

    // count starts at delay-1 so done lands on the last wait cycle
    always_ff @(posedge txclk) begin
        if (!reset_n) begin
            running <= 1'b0;
            remaining <= '0;
        end else if (tx_enable) begin
            if (timer_start) begin
                running <= 1'b1;
                remaining <= powerup_delay - 1'b1;
            end else if (timer_done) begin
                running <= 1'b0;
            end else if (running) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    assign timer_done = running && (remaining == '0);

endmodule

//--- verilog/readout_tx.sv
module readout_tx
    import packet_pkg::*;
    import tx_cfg_pkg::*;
(
    input  logic           txclk,
    input  logic           reset_n,
    input  logic           tx_enable,
    input  logic           push,
    input  logic           enable_dynamic_powerdown,
    input  packet_fields_t fields,
    input  powerup_code_t  powerup_code,
    output logic           tx_out,
    output logic           tx_busy,
    output logic           tx_powerdown,
    output logic           fifo_full
);

    // data path
    packet_t   packet;
    packet_t   head;

    // control between blocks
    logic      fifo_empty;
    logic      pop;
    logic      timer_start;
    logic      timer_done;
    logic      bit_advance;
    logic      last_bit;
    tx_state_t shift_sel;

    //////////////////////////////////////////////////////////////////////
    // packet build and buffer
    //////////////////////////////////////////////////////////////////////

    packet_assembler u_packet_assembler (
        .fields (fields),
        .packet (packet)
    );

    packet_fifo u_packet_fifo (
        .txclk      (txclk),
        .reset_n    (reset_n),
        .push       (push),
        .push_data  (packet),
        .pop        (pop),
        .head       (head),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

    //////////////////////////////////////////////////////////////////////
    // serial transmitter
    //////////////////////////////////////////////////////////////////////

    tx_control u_tx_control (
        .txclk                    (txclk),
        .reset_n                  (reset_n),
        .tx_enable                (tx_enable),
        .enable_dynamic_powerdown (enable_dynamic_powerdown),
        .fifo_empty               (fifo_empty),
        .last_bit                 (last_bit),
        .timer_done               (timer_done),
        .pop                      (pop),
        .timer_start              (timer_start),
        .bit_advance              (bit_advance),
        .tx_busy                  (tx_busy),
        .tx_powerdown             (tx_powerdown),
        .shift_sel                (shift_sel)
    );

    // the pop strobe also loads the fifo head
    tx_shifter u_tx_shifter (
        .txclk       (txclk),
        .reset_n     (reset_n),
        .tx_enable   (tx_enable),
        .load        (pop),
        .bit_advance (bit_advance),
        .load_data   (head),
        .shift_sel   (shift_sel),
        .tx_out      (tx_out),
        .last_bit    (last_bit)
    );

    powerup_timer u_powerup_timer (
        .txclk        (txclk),
        .reset_n      (reset_n),
        .tx_enable    (tx_enable),
        .timer_start  (timer_start),
        .powerup_code (powerup_code),
        .timer_done   (timer_done)
    );

endmodule

//--- verilog/tx_cfg_pkg.sv
package tx_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // serial transmitter configuration
    //////////////////////////////////////////////////////////////////////

    // one state per phase of the line
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_POWERUP,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    localparam int BIT_COUNT_WIDTH = 7;
    localparam int POWERUP_CODE_WIDTH = 3;
    localparam int POWERUP_DELAY_WIDTH = 5;

    typedef logic [BIT_COUNT_WIDTH-1:0] bit_count_t;
    typedef logic [POWERUP_CODE_WIDTH-1:0] powerup_code_t;
    typedef logic [POWERUP_DELAY_WIDTH-1:0] powerup_delay_t;

    // delay grows in steps of four enabled cycles per code
    localparam powerup_delay_t POWERUP_STEP = 5'd4;

    // index of the final data bit, packet is 64 bits
    localparam bit_count_t LAST_BIT_INDEX = 7'd63;

    // line levels
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT = 1'b1;
    localparam logic LINE_IDLE = 1'b1;

endpackage

//--- verilog/tx_control.sv
module tx_control
    import tx_cfg_pkg::*;
(
    input  logic      txclk,
    input  logic      reset_n,
    input  logic      tx_enable,
    input  logic      enable_dynamic_powerdown,
    input  logic      fifo_empty,
    input  logic      last_bit,
    input  logic      timer_done,
    output logic      pop,
    output logic      timer_start,
    output logic      bit_advance,
    output logic      tx_busy,
    output logic      tx_powerdown,
    output tx_state_t shift_sel
);

    tx_state_t state;
    tx_state_t next_state;

    // first state of a new frame
    tx_state_t launch_state;

    // a packet is waiting and the line is free for it
    logic      frame_request;

    //////////////////////////////////////////////////////////////////////
    // frame launch
    //////////////////////////////////////////////////////////////////////

    // a waiting packet leaves from idle or right behind a stop bit
    assign frame_request = tx_enable && !fifo_empty
                           && ((state == TX_IDLE) || (state == TX_STOP));

    // with powerdown on, the PHY needs its wake-up time first
    assign launch_state = enable_dynamic_powerdown ? TX_POWERUP : TX_START;

    // fifo pop doubles as the shifter load
    assign pop = frame_request;
    assign timer_start = frame_request && enable_dynamic_powerdown;

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    // hold the index on the final bit
    assign bit_advance = (state == TX_DATA) && !last_bit;
    assign tx_busy = (state != TX_IDLE);
    // PHY sleeps only while idle, even on stalled cycles
    assign tx_powerdown = (state == TX_IDLE) && enable_dynamic_powerdown;
    assign shift_sel = state;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            TX_IDLE: begin
                if (frame_request) begin
                    next_state = launch_state;
                end
            end
            TX_POWERUP: begin
                // wait out the decoded delay
                if (timer_done) begin
                    next_state = TX_START;
                end
            end
            TX_START: begin
                next_state = TX_DATA;
            end
            TX_DATA: begin
                if (last_bit) begin
                    next_state = TX_STOP;
                end
            end
            TX_STOP: begin
                // chain straight into the next frame when one is waiting
                if (frame_request) begin
                    next_state = launch_state;
                end else begin
                    next_state = TX_IDLE;
                end
            end
            default: begin
                next_state = TX_IDLE;
            end
        endcase
    end

    // stalled cycles freeze the sequence
    always_ff @(posedge txclk) begin
        if (!reset_n) begin
            state <= TX_IDLE;
        end else if (tx_enable) begin
            state <= next_state;
        end
    end

endmodule

//--- verilog/tx_shifter.sv
module tx_shifter
    import packet_pkg::*;
    import tx_cfg_pkg::*;
(
    input  logic      txclk,
    input  logic      reset_n,
    input  logic      tx_enable,
    input  logic      load,
    input  logic      bit_advance,
    input  packet_t   load_data,
    input  tx_state_t shift_sel,
    output logic      tx_out,
    output logic      last_bit
);

    // packet being sent, bit 0 is on the line during data
    packet_t    shift_reg;
    // index of the data bit now on the line
    bit_count_t bit_index;

    //////////////////////////////////////////////////////////////////////
    // packet register and bit counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge txclk) begin
        if (tx_enable) begin
            if (load) begin
                shift_reg <= load_data;
            end else if (bit_advance) begin
                // next bit moves down to bit 0, lsb goes out first
                shift_reg <= shift_reg >> 1;
            end
        end
    end

    always_ff @(posedge txclk) begin
        if (!reset_n) begin
            bit_index <= '0;
        end else if (tx_enable) begin
            if (load) begin
                bit_index <= '0;
            end else if (bit_advance) begin
                bit_index <= bit_index + 1'b1;
            end
        end
    end

    assign last_bit = (bit_index == LAST_BIT_INDEX);

    //////////////////////////////////////////////////////////////////////
    // line driver
    //////////////////////////////////////////////////////////////////////

    // idle and power-up keep the line high
    always_comb begin
        case (shift_sel)
            TX_START: tx_out = START_BIT;
            TX_DATA:  tx_out = shift_reg[0];
            TX_STOP:  tx_out = STOP_BIT;
            default:  tx_out = LINE_IDLE;
        endcase
    end

endmodule
